//--- flist.f
source/spi_bridge_pkg.sv
source/bus_strobe_sync.sv
source/reg_bank.sv
source/transfer_ctrl.sv
source/irq_gen.sv
source/spi_bridge_top.sv
testbench/spi_bridge_tb.sv

//--- run.sh
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --top-module spi_bridge_tb -f flist.f -o spi_bridge_sim \
	> sim.log 2>&1 &&
./obj_dir/spi_bridge_sim >> sim.log 2>&1 ||
echo "** FAIL **" >> sim.log
grep -qF "** FAIL **" sim.log && { echo "simulation failed, see sim.log"; exit 1; } ||
{ echo "simulation passed"; exit 0; }

//--- source/bus_strobe_sync.sv
// turns held avalon read/write levels into one-cycle access strobes and a two-cycle wait_request
`timescale 1ns/1ps

module bus_strobe_sync (
	input  logic                        clk,
	input  logic                        reset_n,
	input  logic                        chip_select,
	input  logic                        read,
	input  logic                        write,
	output logic                        wait_request,
	output spi_bridge_pkg::bus_access_t access
);

	// any request level
	logic req;
	logic req_d1;
	logic req_d2;
	// per-direction delay pairs for edge detect
	logic wr_d1;
	logic wr_d2;
	logic rd_d1;
	logic rd_d2;

	assign req = read | write;

	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			req_d1 <= 1'b0;
			req_d2 <= 1'b0;
			wr_d1  <= 1'b0;
			wr_d2  <= 1'b0;
			rd_d1  <= 1'b0;
			rd_d2  <= 1'b0;
		end
		else
		begin
			req_d1 <= req;
			req_d2 <= req_d1;
			wr_d1  <= write;
			wr_d2  <= wr_d1;
			rd_d1  <= read;
			rd_d2  <= rd_d1;
		end
	end

	// high in cycles 0 and 1 of an access, chip_select not involved
	assign wait_request = req & ~req_d2;

	// rising edge seen one cycle late, so strobe lands in cycle 1
	assign access.wr_strobe = chip_select & wr_d1 & ~wr_d2;
	assign access.rd_strobe = chip_select & rd_d1 & ~rd_d2;

endmodule

//--- source/irq_gen.sv
// latches write/read ready flags on transfer completion and drives the irq line
`timescale 1ns/1ps

module irq_gen (
	input  logic                         clk,
	input  logic                         reset_n,
	input  spi_bridge_pkg::xfer_cmd_t    cmd,
	input  spi_bridge_pkg::irq_cfg_t     irq_cfg,
	input  spi_bridge_pkg::xfer_status_t xfer,
	output spi_bridge_pkg::irq_flags_t   irq_flags,
	output logic                         irq
);

	////////////////////
	// ready flags
	////////////////////

	// each flag only from its own completion
	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
			irq_flags <= '0;
		else if (cmd.irq_clear)
			// clear beats a same-cycle done
			irq_flags <= '0;
		else
		begin
			if (xfer.done_write && irq_cfg.wr_en)
				irq_flags.wr_ready <= 1'b1;
			if (xfer.done_read && irq_cfg.rd_en)
				irq_flags.rd_ready <= 1'b1;
		end
	end

	////////////////////
	// irq line
	////////////////////

	// registered or, one cycle behind the flags
	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
			irq <= 1'b0;
		else if (cmd.irq_clear)
			irq <= 1'b0;
		else
			irq <= irq_flags.wr_ready | irq_flags.rd_ready;
	end

endmodule

//--- source/reg_bank.sv
// register bank: address decode, data-write and enable storage, read mux, command pulse generation
`timescale 1ns/1ps

module reg_bank #(
	parameter int ADDR_W = 8
) (
	input  logic                         clk,
	input  logic                         reset_n,
	input  spi_bridge_pkg::bus_access_t  access,
	input  logic [ADDR_W-1:0]            address,
	input  spi_bridge_pkg::bus_word_u    write_data,
	input  spi_bridge_pkg::xfer_status_t xfer,
	input  spi_bridge_pkg::irq_flags_t   irq_flags,
	input  spi_bridge_pkg::bus_word_t    rx_data,
	output spi_bridge_pkg::bus_word_t    read_data,
	output spi_bridge_pkg::bus_word_t    tx_data,
	output spi_bridge_pkg::xfer_cmd_t    cmd,
	output spi_bridge_pkg::irq_cfg_t     irq_cfg
);

	import spi_bridge_pkg::*;

	// address hits
	logic hit_control;
	logic hit_status;
	logic hit_data_write;
	logic hit_data_read;
	// qualified writes
	logic ctrl_wr;
	logic data_wr;
	// live status view
	status_word_t status_word;

	////////////////////
	// address decode
	////////////////////

	assign hit_control    = (address == ADDR_W'(REG_CONTROL));
	assign hit_status     = (address == ADDR_W'(REG_STATUS));
	assign hit_data_write = (address == ADDR_W'(REG_DATA_WRITE));
	assign hit_data_read  = (address == ADDR_W'(REG_DATA_READ));

	assign ctrl_wr = access.wr_strobe & hit_control;
	assign data_wr = access.wr_strobe & hit_data_write;

	// status word assembled from transfer and irq state
	always_comb
	begin
		status_word              = '0;
		status_word.busy_write   = xfer.busy_write;
		status_word.busy_read    = xfer.busy_read;
		status_word.irq_wr_ready = irq_flags.wr_ready;
		status_word.irq_rd_ready = irq_flags.rd_ready;
	end

	////////////////////
	// write side
	////////////////////

	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			tx_data <= '0;
			irq_cfg <= '0;
		end
		else
		begin
			// enables live on across accesses
			if (ctrl_wr)
			begin
				irq_cfg.wr_en <= write_data.ctrl.irq_wr_en;
				irq_cfg.rd_en <= write_data.ctrl.irq_rd_en;
			end
			// raw view of the same word
			if (data_wr)
				tx_data <= write_data.raw;
		end
	end

	// command bits are not stored, only pulsed for one cycle
	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
			cmd <= '0;
		else
		begin
			cmd <= '0;
			if (ctrl_wr)
			begin
				cmd.start_write <= write_data.ctrl.cmd_write;
				cmd.start_read  <= write_data.ctrl.cmd_read;
				cmd.irq_clear   <= write_data.ctrl.irq_clear;
			end
		end
	end

	////////////////////
	// read side
	////////////////////

	// loaded on the strobe so data is ready as wait_request drops
	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
			read_data <= '0;
		else if (access.rd_strobe)
		begin
			if (hit_status)
				read_data <= bus_word_t'(status_word);
			else if (hit_data_read)
				read_data <= rx_data;
			else
				// write-only and unmapped read as zero
				read_data <= '0;
		end
	end

endmodule

//--- source/spi_bridge_pkg.sv
// shared addresses, word layouts and inter-block structs for the avalon to spi register bridge
package spi_bridge_pkg;

	// bus and register width
	parameter int DATA_W = 32;

	////////////////////
	// register map
	////////////////////

	typedef enum logic [7:0] {
		REG_CONTROL    = 8'd0,
		REG_STATUS     = 8'd1,
		REG_DATA_WRITE = 8'd2,
		REG_DATA_READ  = 8'd3
	} reg_addr_e;

	// raw data word
	typedef logic [DATA_W-1:0] bus_word_t;

	// control register view of a written word
	typedef struct packed {
		logic [DATA_W-6:0] reserved;
		logic              irq_rd_en;
		logic              irq_wr_en;
		logic              irq_clear;
		logic              cmd_read;
		logic              cmd_write;
	} ctrl_word_t;

	// master write word, control fields at addr 0, raw data at addr 2
	typedef union packed {
		ctrl_word_t ctrl;
		bus_word_t  raw;
	} bus_word_u;

	// status register layout
	typedef struct packed {
		logic [DATA_W-6:0] zero_hi;
		logic              irq_rd_ready;
		logic              irq_wr_ready;
		logic              zero_2;
		logic              busy_read;
		logic              busy_write;
	} status_word_t;

	////////////////////
	// block to block
	////////////////////

	// one-cycle bus access strobes
	typedef struct packed {
		logic wr_strobe;
		logic rd_strobe;
	} bus_access_t;

	// one-cycle command pulses from the control register
	typedef struct packed {
		logic start_write;
		logic start_read;
		logic irq_clear;
	} xfer_cmd_t;

	// stored interrupt enables
	typedef struct packed {
		logic wr_en;
		logic rd_en;
	} irq_cfg_t;

	// busy levels plus done pulses
	typedef struct packed {
		logic busy_write;
		logic busy_read;
		logic done_write;
		logic done_read;
	} xfer_status_t;

	// latched ready flags
	typedef struct packed {
		logic wr_ready;
		logic rd_ready;
	} irq_flags_t;

endpackage

//--- source/spi_bridge_top.sv
// top level of the avalon-to-spi register bridge, connects bus sync, registers, transfer FSM and irq
`timescale 1ns/1ps

module spi_bridge_top #(
	parameter int ADDR_W           = 8,
	parameter int DONE_SYNC_STAGES = 2
) (
	input  logic                      clk,
	input  logic                      reset_n,
	input  logic                      chip_select,
	input  logic [ADDR_W-1:0]         address,
	input  logic                      read,
	input  logic                      write,
	input  spi_bridge_pkg::bus_word_u write_data,
	input  logic                      data_pack_ready,
	input  spi_bridge_pkg::bus_word_t data_read_from_spi,
	output spi_bridge_pkg::bus_word_t read_data,
	output logic                      wait_request,
	output spi_bridge_pkg::bus_word_t data_write_to_spi,
	output logic                      go_transfer,
	output logic                      irq
);

	import spi_bridge_pkg::*;

	// bus strobes into the register bank
	bus_access_t  access;
	// command pulses and enables out of the register bank
	xfer_cmd_t    cmd;
	irq_cfg_t     irq_cfg;
	// transfer state and captured word
	xfer_status_t xfer;
	bus_word_t    rx_data;
	// ready flags back for status readout
	irq_flags_t   irq_flags;

	bus_strobe_sync u_bus_strobe_sync (
		.clk          (clk),
		.reset_n      (reset_n),
		.chip_select  (chip_select),
		.read         (read),
		.write        (write),
		.wait_request (wait_request),
		.access       (access)
	);

	reg_bank #(
		.ADDR_W (ADDR_W)
	) u_reg_bank (
		.clk        (clk),
		.reset_n    (reset_n),
		.access     (access),
		.address    (address),
		.write_data (write_data),
		.xfer       (xfer),
		.irq_flags  (irq_flags),
		.rx_data    (rx_data),
		.read_data  (read_data),
		.tx_data    (data_write_to_spi),
		.cmd        (cmd),
		.irq_cfg    (irq_cfg)
	);

	transfer_ctrl #(
		.DONE_SYNC_STAGES (DONE_SYNC_STAGES)
	) u_transfer_ctrl (
		.clk                (clk),
		.reset_n            (reset_n),
		.cmd                (cmd),
		.data_pack_ready    (data_pack_ready),
		.data_read_from_spi (data_read_from_spi),
		.go_transfer        (go_transfer),
		.xfer               (xfer),
		.rx_data            (rx_data)
	);

	irq_gen u_irq_gen (
		.clk       (clk),
		.reset_n   (reset_n),
		.cmd       (cmd),
		.irq_cfg   (irq_cfg),
		.xfer      (xfer),
		.irq_flags (irq_flags),
		.irq       (irq)
	);

endmodule

//--- source/transfer_ctrl.sv
// spi transfer FSM: start on command pulse, emit go_transfer, track busy, end on data_pack_ready fall
`timescale 1ns/1ps

module transfer_ctrl #(
	parameter int DONE_SYNC_STAGES = 2
) (
	input  logic                         clk,
	input  logic                         reset_n,
	input  spi_bridge_pkg::xfer_cmd_t    cmd,
	input  logic                         data_pack_ready,
	input  spi_bridge_pkg::bus_word_t    data_read_from_spi,
	output logic                         go_transfer,
	output spi_bridge_pkg::xfer_status_t xfer,
	output spi_bridge_pkg::bus_word_t    rx_data
);

	typedef enum logic [1:0] {
		state_idle,
		state_write_busy,
		state_read_busy
	} state_e;

	state_e state;
	// synchronizer chain on data_pack_ready
	logic [DONE_SYNC_STAGES-1:0] ready_sync;
	// last synced value, for edge detect
	logic ready_prev;
	logic ready_fall;
	logic start_any;

	////////////////////
	// completion detect
	////////////////////

	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			ready_sync <= '0;
			ready_prev <= 1'b0;
		end
		else
		begin
			ready_sync[0] <= data_pack_ready;
			for (int i = 1; i < DONE_SYNC_STAGES; i++)
				ready_sync[i] <= ready_sync[i-1];
			ready_prev <= ready_sync[DONE_SYNC_STAGES-1];
		end
	end

	// packet done when the synced level drops
	assign ready_fall = ready_prev & ~ready_sync[DONE_SYNC_STAGES-1];

	assign start_any = cmd.start_write | cmd.start_read;

	////////////////////
	// state machine
	////////////////////

	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
			state <= state_idle;
		else
		begin
			case (state)
				state_idle:
				begin
					// write wins when both are set
					if (cmd.start_write)
						state <= state_write_busy;
					else if (cmd.start_read)
						state <= state_read_busy;
				end
				state_write_busy:
				begin
					if (ready_fall)
						state <= state_idle;
				end
				state_read_busy:
				begin
					if (ready_fall)
						state <= state_idle;
				end
				default:
					state <= state_idle;
			endcase
		end
	end

	// one pulse per accepted start, starts while busy are dropped
	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
			go_transfer <= 1'b0;
		else
			go_transfer <= (state == state_idle) & start_any;
	end

	// busy follows state one cycle later and clears with the done pulse
	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
			xfer <= '0;
		else
		begin
			xfer.busy_write <= (state == state_write_busy) & ~ready_fall;
			xfer.busy_read  <= (state == state_read_busy) & ~ready_fall;
			xfer.done_write <= (state == state_write_busy) & ready_fall;
			xfer.done_read  <= (state == state_read_busy) & ready_fall;
		end
	end

	// data-read register, loaded as the read ends
	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
			rx_data <= '0;
		else if ((state == state_read_busy) && ready_fall)
			rx_data <= data_read_from_spi;
	end

endmodule

//--- testbench/spi_bridge_tb.sv
// directed testbench for the avalon-to-spi register bridge, top module spi_bridge_tb, built from flist.f
`timescale 1ns/1ps

module spi_bridge_tb;

	import spi_bridge_pkg::*;

	localparam int ADDR_W           = 8;
	localparam int DONE_SYNC_STAGES = 2;
	// limits for every polling loop
	localparam int BUS_TIMEOUT      = 20;
	localparam int IRQ_TIMEOUT      = 200;
	localparam int POLL_TIMEOUT     = 50;

	logic              clk;
	logic              reset_n;
	logic              chip_select;
	logic [ADDR_W-1:0] address;
	logic              read;
	logic              write;
	bus_word_u         write_data;
	logic              data_pack_ready;
	bus_word_t         data_read_from_spi;
	bus_word_t         read_data;
	logic              wait_request;
	bus_word_t         data_write_to_spi;
	logic              go_transfer;
	logic              irq;

	// cycles with go_transfer high, over the whole run
	int go_count    = 0;
	int unsigned seed_value;

	spi_bridge_top #(
		.ADDR_W           (ADDR_W),
		.DONE_SYNC_STAGES (DONE_SYNC_STAGES)
	) dut (
		.clk                (clk),
		.reset_n            (reset_n),
		.chip_select        (chip_select),
		.address            (address),
		.read               (read),
		.write              (write),
		.write_data         (write_data),
		.data_pack_ready    (data_pack_ready),
		.data_read_from_spi (data_read_from_spi),
		.read_data          (read_data),
		.wait_request       (wait_request),
		.data_write_to_spi  (data_write_to_spi),
		.go_transfer        (go_transfer),
		.irq                (irq)
	);

	// 4 ns clock
	initial
		clk = 1'b0;
	always
		#2 clk = ~clk;

	// sampled mid-cycle, away from the driving edge
	always @(negedge clk)
	begin
		if (reset_n && go_transfer)
			go_count++;
	end

	////////////////////
	// reporting
	////////////////////

	task automatic stop_with_failure();
		$display("** FAIL **");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_word(input bus_word_t got, input bus_word_t exp, input string name);
		if (got !== exp)
		begin
			$display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
			stop_with_failure();
		end
	endtask

	task automatic check_status(input status_word_t got, input status_word_t exp,
		input string name);
		if (got !== exp)
		begin
			$display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
			stop_with_failure();
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string name);
		if (got !== exp)
		begin
			$display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp);
			stop_with_failure();
		end
	endtask

	////////////////////
	// word builders
	////////////////////

	function automatic bus_word_u control_word(input logic wr, input logic rd, input logic clr,
		input logic wr_en, input logic rd_en);
		bus_word_u w;
		w                = '0;
		w.ctrl.cmd_write = wr;
		w.ctrl.cmd_read  = rd;
		w.ctrl.irq_clear = clr;
		w.ctrl.irq_wr_en = wr_en;
		w.ctrl.irq_rd_en = rd_en;
		return w;
	endfunction

	// expected status from the four visible flags
	function automatic status_word_t status_of(input logic bw, input logic br, input logic wrr,
		input logic rdr);
		status_word_t s;
		s              = '0;
		s.busy_write   = bw;
		s.busy_read    = br;
		s.irq_wr_ready = wrr;
		s.irq_rd_ready = rdr;
		return s;
	endfunction

	////////////////////
	// bus driver
	////////////////////

	// one access, held until wait_request drops, then a three cycle gap
	task automatic bus_access(input logic is_write, input logic cs, input reg_addr_e addr,
		input bus_word_u wdata, output bus_word_t rdata);
		int n;
		n = 0;
		@(posedge clk);
		chip_select <= cs;
		address     <= addr;
		write_data  <= wdata;
		write       <= is_write;
		read        <= ~is_write;
		@(negedge clk);
		while (wait_request)
		begin
			n++;
			if (n > BUS_TIMEOUT)
			begin
				$display("wait_request never dropped during a bus access");
				stop_with_failure();
			end
			@(negedge clk);
		end
		// two wait cycles on every access, chip select or not
		if (n != 2)
		begin
			$display("wait_request was high for %0d cycles instead of two", n);
			stop_with_failure();
		end
		rdata = read_data;
		@(posedge clk);
		write       <= 1'b0;
		read        <= 1'b0;
		chip_select <= 1'b0;
		repeat (3) @(posedge clk);
	endtask

	task automatic bus_write(input reg_addr_e addr, input bus_word_u wdata, input logic cs);
		bus_word_t unused;
		bus_access(1'b1, cs, addr, wdata, unused);
	endtask

	task automatic bus_read(input reg_addr_e addr, output bus_word_t rdata);
		bus_access(1'b0, 1'b1, addr, '0, rdata);
	endtask

	////////////////////
	// spi side model
	////////////////////

	// packet done after a random delay, then ready again
	task automatic spi_finish(input bus_word_t word);
		repeat (2 + $urandom % 10) @(posedge clk);
		data_read_from_spi <= word;
		data_pack_ready    <= 1'b0;
		repeat (DONE_SYNC_STAGES + 3) @(posedge clk);
		data_pack_ready    <= 1'b1;
	endtask

	task automatic wait_irq();
		int n;
		n = 0;
		@(negedge clk);
		while (!irq)
		begin
			n++;
			if (n > IRQ_TIMEOUT)
			begin
				$display("irq did not rise after the transfer finished");
				stop_with_failure();
			end
			@(negedge clk);
		end
	endtask

	// poll status until both busy bits are clear
	task automatic wait_idle(output status_word_t st);
		bus_word_t rd;
		int polls;
		polls = 0;
		bus_read(REG_STATUS, rd);
		st = status_word_t'(rd);
		while (st.busy_write || st.busy_read)
		begin
			polls++;
			if (polls > POLL_TIMEOUT)
			begin
				$display("transfer never finished, status stayed busy");
				stop_with_failure();
			end
			bus_read(REG_STATUS, rd);
			st = status_word_t'(rd);
		end
	endtask

	////////////////////
	// tests
	////////////////////

	task automatic test_reset_state();
		bus_word_t rd;
		@(negedge clk);
		check_bit(irq, 1'b0, "irq");
		check_bit(go_transfer, 1'b0, "go_transfer");
		check_bit(wait_request, 1'b0, "wait_request");
		bus_read(REG_STATUS, rd);
		check_status(status_word_t'(rd), status_of(0, 0, 0, 0), "status");
		bus_read(REG_DATA_READ, rd);
		check_word(rd, '0, "data_read");
	endtask

	task automatic test_chip_select();
		bus_word_u w;
		w.raw = $urandom;
		// ignored without chip select, register keeps its reset value
		bus_write(REG_DATA_WRITE, w, 1'b0);
		check_word(data_write_to_spi, '0, "data_write_to_spi");
		bus_write(REG_DATA_WRITE, w, 1'b1);
		check_word(data_write_to_spi, w.raw, "data_write_to_spi");
	endtask

	task automatic test_write_transfer();
		bus_word_t rd;
		status_word_t st;
		int go_before;
		go_before = go_count;
		bus_write(REG_CONTROL, control_word(1, 0, 0, 0, 0), 1'b1);
		check_word(bus_word_t'(go_count - go_before), 32'd1, "go_transfer pulses");
		bus_read(REG_STATUS, rd);
		check_status(status_word_t'(rd), status_of(1, 0, 0, 0), "status");
		spi_finish($urandom);
		wait_idle(st);
		check_status(st, status_of(0, 0, 0, 0), "status");
	endtask

	task automatic test_read_transfer();
		bus_word_t rd;
		bus_word_t word;
		status_word_t st;
		word = $urandom;
		bus_write(REG_CONTROL, control_word(0, 1, 0, 0, 0), 1'b1);
		bus_read(REG_STATUS, rd);
		check_status(status_word_t'(rd), status_of(0, 1, 0, 0), "status");
		spi_finish(word);
		wait_idle(st);
		bus_read(REG_DATA_READ, rd);
		check_word(rd, word, "data_read");
	endtask

	task automatic test_interrupts();
		bus_word_t rd;
		status_word_t st;
		// write enable and start in the same control write
		bus_write(REG_CONTROL, control_word(1, 0, 0, 1, 0), 1'b1);
		spi_finish($urandom);
		wait_irq();
		wait_idle(st);
		check_status(st, status_of(0, 0, 1, 0), "status");
		// clear also drops both enables
		bus_write(REG_CONTROL, control_word(0, 0, 1, 0, 0), 1'b1);
		@(negedge clk);
		check_bit(irq, 1'b0, "irq");
		wait_idle(st);
		check_status(st, status_of(0, 0, 0, 0), "status");
		// no enables, no irq
		bus_write(REG_CONTROL, control_word(0, 1, 0, 0, 0), 1'b1);
		spi_finish($urandom);
		wait_idle(st);
		repeat (4) @(negedge clk);
		check_bit(irq, 1'b0, "irq");
		// fresh read, flags would have latched by now
		bus_read(REG_STATUS, rd);
		check_status(status_word_t'(rd), status_of(0, 0, 0, 0), "status");
	endtask

	task automatic test_start_while_busy();
		status_word_t st;
		int go_before;
		go_before = go_count;
		bus_write(REG_CONTROL, control_word(1, 0, 0, 0, 0), 1'b1);
		// second start lands while busy_write is set
		bus_write(REG_CONTROL, control_word(1, 0, 0, 0, 0), 1'b1);
		spi_finish($urandom);
		wait_idle(st);
		check_word(bus_word_t'(go_count - go_before), 32'd1, "go_transfer pulses");
	endtask

	////////////////////
	// main sequence
	////////////////////

	initial
	begin
		seed_value         = $urandom(32'heabbb43d);
		reset_n            = 1'b0;
		chip_select        = 1'b0;
		address            = '0;
		read               = 1'b0;
		write              = 1'b0;
		write_data         = '0;
		data_pack_ready    = 1'b1;
		data_read_from_spi = '0;
		repeat (16) @(posedge clk);
		reset_n <= 1'b1;
		repeat (2) @(posedge clk);

		test_reset_state();
		test_chip_select();
		test_write_transfer();
		test_read_transfer();
		test_interrupts();
		test_start_while_busy();

		$display("** PASS **");
		$finish;
	end

endmodule
